//--- hw/aluPkg.sv
/*
 Shared widths, opcodes, execution classes and the flag layout of the ALU.
 Opcodes 1/15 and 32/33 are aliases from the ALU's point of view.
 Codes not listed here decode to clsInvalid.
*/
package aluPkg;

	// Widths
	localparam int dataWidth = 32; // Operand and result width
	localparam int opWidth   = 6;  // Wide enough for the immediate codes 32 and 33

	typedef logic [dataWidth-1:0] dataT;
	typedef logic [opWidth-1:0]   opcodeT;

	// Raw opcode values
	localparam opcodeT opNop    = 6'd0;
	localparam opcodeT opAdd    = 6'd1;
	localparam opcodeT opAddIdx = 6'd15; // Load base with index, same adder as ADD
	localparam opcodeT opSub    = 6'd2;
	localparam opcodeT opAnd    = 6'd3;
	localparam opcodeT opOr     = 6'd4;
	localparam opcodeT opNeg    = 6'd5;
	localparam opcodeT opXor    = 6'd6;
	localparam opcodeT opComp   = 6'd7;  // One's complement
	localparam opcodeT opLsr    = 6'd8;
	localparam opcodeT opAsr    = 6'd9;
	localparam opcodeT opLsl    = 6'd10;
	localparam opcodeT opRor    = 6'd11; // Through carry
	localparam opcodeT opRol    = 6'd12; // Through carry
	localparam opcodeT opMove   = 6'd13; // Passes A
	localparam opcodeT opLdri   = 6'd14; // Passes B
	localparam opcodeT opLdi    = 6'd32; // Immediate arrives on B
	localparam opcodeT opLdui   = 6'd33;

	// Execution classes after decode
	typedef enum logic [3:0] {
		clsNop,
		clsAdd,
		clsSub,
		clsNeg,
		clsAnd,
		clsOr,
		clsXor,
		clsComp,
		clsLsr,
		clsAsr,
		clsLsl,
		clsRor,
		clsRol,
		clsPassA,
		clsPassB,
		clsInvalid
	} opClassT;

	// Condition codes, {inr, n, z, v, c}
	typedef logic [4:0] flagsT;

	localparam int flagInr   = 4; // Instruction not recognized
	localparam int flagNeg   = 3;
	localparam int flagZero  = 2;
	localparam int flagOvf   = 1;
	localparam int flagCarry = 0;

endpackage

//--- hw/aluDecodedIf.sv
/*
 Decoded operation from stage 1 to the execution units and stage 2.
 No handshake, an item is consumed in the cycle valid is high.
*/
`timescale 1ns/1ps

interface aluDecodedIf;

	logic            valid;   // Item present this cycle
	aluPkg::opClassT opClass; // Execution class
	aluPkg::dataT    a;       // Operand A
	aluPkg::dataT    b;       // Operand B or immediate

	// Stage 1 side
	modport decoder (
		output valid,
		output opClass,
		output a,
		output b
	);

	// Execution and flag side, read only
	modport exec (
		input valid,
		input opClass,
		input a,
		input b
	);

endinterface

//--- hw/opDecoder.sv
/*
 Stage 1, one cycle of latency, one operation accepted per cycle.
 Operands are captured only while inValid is high.
 Any opcode outside the package list becomes clsInvalid.
*/
`timescale 1ns/1ps

module opDecoder (
	input  logic           Clock,
	input  logic           arstN,
	input  logic           inValid,
	input  aluPkg::opcodeT opcode,
	input  aluPkg::dataT   a,
	input  aluPkg::dataT   b,
	aluDecodedIf.decoder   dec
);

	aluPkg::opClassT nextClass; // Class of the incoming opcode

	// Opcode to execution class
	always_comb begin
		case (opcode)
			aluPkg::opNop:    nextClass = aluPkg::clsNop;
			aluPkg::opAdd,
			aluPkg::opAddIdx: nextClass = aluPkg::clsAdd; // Base plus index is a plain add here
			aluPkg::opSub:    nextClass = aluPkg::clsSub;
			aluPkg::opAnd:    nextClass = aluPkg::clsAnd;
			aluPkg::opOr:     nextClass = aluPkg::clsOr;
			aluPkg::opNeg:    nextClass = aluPkg::clsNeg;
			aluPkg::opXor:    nextClass = aluPkg::clsXor;
			aluPkg::opComp:   nextClass = aluPkg::clsComp;
			aluPkg::opLsr:    nextClass = aluPkg::clsLsr;
			aluPkg::opAsr:    nextClass = aluPkg::clsAsr;
			aluPkg::opLsl:    nextClass = aluPkg::clsLsl;
			aluPkg::opRor:    nextClass = aluPkg::clsRor;
			aluPkg::opRol:    nextClass = aluPkg::clsRol;
			aluPkg::opMove:   nextClass = aluPkg::clsPassA; // Memory side lives elsewhere
			aluPkg::opLdri,
			aluPkg::opLdi,
			aluPkg::opLdui:   nextClass = aluPkg::clsPassB; // Address or immediate on B
			default:          nextClass = aluPkg::clsInvalid;
		endcase
	end

	// Control part of the stage register
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			dec.valid   <= 1'b0;
			dec.opClass <= aluPkg::clsNop;
		end else begin
			dec.valid <= inValid;
			if (inValid) begin
				dec.opClass <= nextClass;
			end
		end
	end

	// Operand payload
	always_ff @(posedge Clock) begin
		if (inValid) begin
			dec.a <= a;
			dec.b <= b;
		end
	end

endmodule

//--- hw/arithUnit.sv
/*
 Combinational add, subtract and negate on one shared 33-bit adder.
 Carry is carry-out for add, borrow for subtract, 0 for negate.
 Outputs are don't-care for non-arithmetic classes.
*/
`timescale 1ns/1ps

module arithUnit (
	aluDecodedIf.exec    dec,
	output aluPkg::dataT arithResult,
	output logic         arithOvf,
	output logic         arithCarry
);

	localparam int msb = aluPkg::dataWidth - 1; // Sign bit position

	aluPkg::dataT                opX;  // Adder left input
	aluPkg::dataT                opY;  // Adder right input
	logic                        cin;  // Adder carry in
	logic [aluPkg::dataWidth:0]  sum;  // Extra bit holds the carry out

	// Operand steering, a-b is a+~b+1 and -a is 0+~a+1
	always_comb begin
		case (dec.opClass)
			aluPkg::clsSub: begin
				opX = dec.a;
				opY = ~dec.b;
				cin = 1'b1;
			end
			aluPkg::clsNeg: begin
				opX = '0;
				opY = ~dec.a;
				cin = 1'b1;
			end
			default: begin // Add
				opX = dec.a;
				opY = dec.b;
				cin = 1'b0;
			end
		endcase
	end

	assign sum = {1'b0, opX} + {1'b0, opY} + {{aluPkg::dataWidth{1'b0}}, cin};
	assign arithResult = sum[msb:0];

	// Signed overflow and carry, both taken from the new result
	always_comb begin
		case (dec.opClass)
			aluPkg::clsSub: begin
				arithOvf   = (dec.a[msb] != dec.b[msb]) && (sum[msb] != dec.a[msb]);
				arithCarry = ~sum[aluPkg::dataWidth]; // No carry out means a < b unsigned
			end
			aluPkg::clsNeg: begin
				arithOvf   = dec.a[msb] && sum[msb]; // Only the most negative number
				arithCarry = 1'b0;
			end
			default: begin
				arithOvf   = (dec.a[msb] == dec.b[msb]) && (sum[msb] != dec.a[msb]);
				arithCarry = sum[aluPkg::dataWidth];
			end
		endcase
	end

endmodule

//--- hw/shiftLogicUnit.sv
/*
 Combinational bitwise, one-bit shift, rotate-through-carry and pass operations.
 Rotates read the stored carry, so their result depends on earlier operations.
 Shifts and rotates move exactly one bit position.
*/
`timescale 1ns/1ps

module shiftLogicUnit (
	aluDecodedIf.exec    dec,
	input  logic         carryIn,
	output aluPkg::dataT logicResult,
	output logic         logicCarry
);

	localparam int msb = aluPkg::dataWidth - 1;

	always_comb begin
		logicCarry = 1'b0; // Only shifts and rotates produce a carry
		case (dec.opClass)
			aluPkg::clsAnd:  logicResult = dec.a & dec.b;
			aluPkg::clsOr:   logicResult = dec.a | dec.b;
			aluPkg::clsXor:  logicResult = dec.a ^ dec.b;
			aluPkg::clsComp: logicResult = ~dec.a; // One's complement

			// Right moves, bit 0 drops into carry
			aluPkg::clsLsr: begin
				logicResult = {1'b0, dec.a[msb:1]};
				logicCarry  = dec.a[0];
			end
			aluPkg::clsAsr: begin
				logicResult = {dec.a[msb], dec.a[msb:1]}; // Sign fill
				logicCarry  = dec.a[0];
			end
			aluPkg::clsRor: begin
				logicResult = {carryIn, dec.a[msb:1]}; // Old carry into the top
				logicCarry  = dec.a[0];
			end

			// Left moves, sign bit drops into carry
			aluPkg::clsLsl: begin
				logicResult = {dec.a[msb-1:0], 1'b0};
				logicCarry  = dec.a[msb];
			end
			aluPkg::clsRol: begin
				logicResult = {dec.a[msb-1:0], carryIn}; // Old carry into bit 0
				logicCarry  = dec.a[msb];
			end

			aluPkg::clsPassA: logicResult = dec.a; // Move
			aluPkg::clsPassB: logicResult = dec.b; // Loads

			default: logicResult = '0;
		endcase
	end

endmodule

//--- hw/flagRegister.sv
/*
 Stage 2, one cycle of latency. Selects the result and keeps the sticky flags.
 NOP and unrecognized operations give a result of 0.
 On NOP the flags hold and ccrEnable stays low.
 Overflow and carry change only for the classes that produce them.
*/
`timescale 1ns/1ps

module flagRegister (
	input  logic          Clock,
	input  logic          arstN,
	aluDecodedIf.exec     dec,
	input  aluPkg::dataT  arithResult,
	input  logic          arithOvf,
	input  logic          arithCarry,
	input  aluPkg::dataT  logicResult,
	input  logic          logicCarry,
	output logic          carryIn,
	output logic          outValid,
	output aluPkg::dataT  result,
	output aluPkg::flagsT flags,
	output logic          ccrEnable
);

	logic         isArith;     // Result comes from the adder
	logic         writesOvf;   // Class owns the overflow flag
	logic         writesCarry; // Class owns the carry flag
	logic         isEmpty;     // NOP or unrecognized, result forced to 0
	logic         updateCcr;   // Flags written this cycle
	aluPkg::dataT nextResult;  // Selected result
	logic         nextCarry;   // Carry from whichever unit is active

	// Class properties
	always_comb begin
		isArith     = 1'b0;
		writesOvf   = 1'b0;
		writesCarry = 1'b0;
		isEmpty     = 1'b0;
		case (dec.opClass)
			aluPkg::clsAdd,
			aluPkg::clsSub,
			aluPkg::clsNeg: begin
				isArith     = 1'b1;
				writesOvf   = 1'b1;
				writesCarry = 1'b1; // Negate writes 0
			end
			aluPkg::clsLsr,
			aluPkg::clsAsr,
			aluPkg::clsLsl,
			aluPkg::clsRor,
			aluPkg::clsRol: writesCarry = 1'b1;
			aluPkg::clsNop,
			aluPkg::clsInvalid: isEmpty = 1'b1;
			default: ; // Bitwise and pass classes touch only n, z, inr
		endcase
	end

	assign nextResult = isEmpty ? '0 : (isArith ? arithResult : logicResult);
	assign nextCarry  = isArith ? arithCarry : logicCarry;
	assign updateCcr  = dec.valid && (dec.opClass != aluPkg::clsNop);

	assign carryIn = flags[aluPkg::flagCarry]; // Stored carry for the rotates

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			outValid  <= 1'b0;
			ccrEnable <= 1'b0;
			result    <= '0;
			flags     <= '0;
		end else begin
			outValid  <= dec.valid;  // Fixed latency, no stall
			ccrEnable <= updateCcr;
			if (dec.valid) begin
				result <= nextResult;
			end
			if (updateCcr) begin
				flags[aluPkg::flagInr]  <= (dec.opClass == aluPkg::clsInvalid);
				flags[aluPkg::flagNeg]  <= nextResult[aluPkg::dataWidth-1];
				flags[aluPkg::flagZero] <= (nextResult == '0);
				if (writesOvf) begin
					flags[aluPkg::flagOvf] <= arithOvf;
				end
				if (writesCarry) begin
					flags[aluPkg::flagCarry] <= nextCarry;
				end
			end
		end
	end

endmodule

//--- hw/aluTop.sv
/*
 Two-stage pipelined 32-bit ALU with condition codes.
 Output appears two edges after an accepted input, with outValid for one cycle.
 There is no back-pressure, the consumer takes every output.
*/
`timescale 1ns/1ps

module aluTop (
	input  logic           Clock,
	input  logic           arstN,
	input  logic           inValid,
	input  aluPkg::opcodeT opcode,
	input  aluPkg::dataT   a,
	input  aluPkg::dataT   b,
	output logic           outValid,
	output aluPkg::dataT   result,
	output aluPkg::flagsT  flags,
	output logic           ccrEnable
);

	aluPkg::dataT arithResult;
	logic         arithOvf;
	logic         arithCarry;
	aluPkg::dataT logicResult;
	logic         logicCarry;
	logic         carryIn;     // Stored carry back to the rotates

	aluDecodedIf decBus (); // Stage 1 to stage 2

	opDecoder opDecoder_inst (
		.Clock   (Clock),
		.arstN   (arstN),
		.inValid (inValid),
		.opcode  (opcode),
		.a       (a),
		.b       (b),
		.dec     (decBus.decoder)
	);

	arithUnit arithUnit_inst (
		.dec         (decBus.exec),
		.arithResult (arithResult),
		.arithOvf    (arithOvf),
		.arithCarry  (arithCarry)
	);

	shiftLogicUnit shiftLogicUnit_inst (
		.dec         (decBus.exec),
		.carryIn     (carryIn),
		.logicResult (logicResult),
		.logicCarry  (logicCarry)
	);

	flagRegister flagRegister_inst (
		.Clock       (Clock),
		.arstN       (arstN),
		.dec         (decBus.exec),
		.arithResult (arithResult),
		.arithOvf    (arithOvf),
		.arithCarry  (arithCarry),
		.logicResult (logicResult),
		.logicCarry  (logicCarry),
		.carryIn     (carryIn),
		.outValid    (outValid),
		.result      (result),
		.flags       (flags),
		.ccrEnable   (ccrEnable)
	);

endmodule

//--- sim/aluTb.sv
/*
 Self-checking testbench for aluTop. Replays sim/aluTestdata.txt.
 Expected flags in the file are sticky from line to line, so line order matters.
 Stops at the first mismatch. At most maxLines vectors are read.
*/
`timescale 1ns/1ps

module aluTb;

	localparam int clkPeriod = 8;
	localparam int maxLines  = 64;
	localparam int margin    = 20; // Watchdog slack in cycles

	logic           Clock;
	logic           arstN;
	logic           inValid;
	aluPkg::opcodeT opcode;
	aluPkg::dataT   a;
	aluPkg::dataT   b;
	logic           outValid;
	aluPkg::dataT   result;
	aluPkg::flagsT  flags;
	logic           ccrEnable;

	logic [31:0]   vecMem [0:5*maxLines-1]; // Five words per line
	aluPkg::dataT  expResult [$];
	aluPkg::flagsT expFlags [$];
	logic          expCcr [$];
	int            expCycle [$]; // Cycle in which outValid must show up
	int            gapLen [0:maxLines-1];
	int            numLines;
	int            limitCycles = 0;
	int            cycleCount = 0;
	integer        seed;

	aluTop aluTop_inst (
		.Clock     (Clock),
		.arstN     (arstN),
		.inValid   (inValid),
		.opcode    (opcode),
		.a         (a),
		.b         (b),
		.outValid  (outValid),
		.result    (result),
		.flags     (flags),
		.ccrEnable (ccrEnable)
	);

	always #(clkPeriod / 2) Clock = ~Clock;

	always @(posedge Clock) cycleCount <= cycleCount + 1;

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compareData(input string name, input aluPkg::dataT got,
			input aluPkg::dataT exp);
		if (got !== exp) begin
			stopRun($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic compareFlags(input string name, input aluPkg::flagsT got,
			input aluPkg::flagsT exp);
		if (got !== exp) begin
			stopRun($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic compareBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stopRun($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	// Output monitor samples away from the driving edge
	always @(negedge Clock) begin
		int dueCycle;
		if (arstN && outValid) begin
			if (expResult.size() == 0) begin
				stopRun("An output arrived with no input in flight");
			end else begin
				dueCycle = expCycle.pop_front();
				if (dueCycle != cycleCount) begin
					stopRun($sformatf("[FAIL] %0t outValid cycle got %0d expected %0d",
						$time, cycleCount, dueCycle));
				end
				compareData("result", result, expResult.pop_front());
				compareFlags("flags", flags, expFlags.pop_front());
				compareBit("ccrEnable", ccrEnable, expCcr.pop_front());
			end
		end
	end

	// Watchdog sized from the vector count and the gaps
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge Clock);
		$display("Timeout after %0d cycles, the outputs stopped arriving", limitCycles);
		$display("Done: errors found");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		int base;
		Clock   = 1'b0;
		arstN   = 1'b0;
		inValid = 1'b0;
		opcode  = '0;
		a       = '0;
		b       = '0;
		seed    = 97417;
		$readmemh("sim/aluTestdata.txt", vecMem);
		numLines = 0;
		while (numLines < maxLines && !$isunknown(vecMem[5*numLines])) numLines++;
		if (numLines == 0) begin
			stopRun("No vectors could be read from sim/aluTestdata.txt");
		end
		limitCycles = numLines + margin;
		for (int i = 0; i < numLines; i++) begin
			gapLen[i] = $unsigned($random(seed)) % 3; // Idle cycles before line i
			limitCycles += gapLen[i];
		end

		repeat (4) @(posedge Clock);
		#1 arstN = 1'b1;
		@(negedge Clock); // Reset values before any input
		compareBit("outValid", outValid, 1'b0);
		compareBit("ccrEnable", ccrEnable, 1'b0);
		compareData("result", result, '0);
		compareFlags("flags", flags, '0);

		for (int i = 0; i < numLines; i++) begin
			base = 5 * i;
			repeat (gapLen[i]) begin
				@(posedge Clock);
				#1 inValid = 1'b0;
			end
			@(posedge Clock);
			#1;
			inValid = 1'b1;
			opcode  = vecMem[base][aluPkg::opWidth-1:0];
			a       = vecMem[base+1];
			b       = vecMem[base+2];
			expResult.push_back(vecMem[base+3]);
			expFlags.push_back(vecMem[base+4][4:0]);
			expCcr.push_back(opcode != aluPkg::opNop); // NOP never writes the CCR
			expCycle.push_back(cycleCount + 2);        // Two edges through the pipe
		end
		@(posedge Clock);
		#1 inValid = 1'b0;
		wait (expResult.size() == 0);
		repeat (3) @(posedge Clock); // Catch any stray output

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- sim/aluTestdata.txt
// opcode a b result flags, all hex, flags = {inr, n, z, v, c}
// flags carry over from the line before, keep the order
01 00000001 00000002 00000003 00
01 7fffffff 00000001 80000000 0a
0f ffffffff 00000001 00000000 05
01 80000000 80000000 00000000 07
02 00000005 00000003 00000002 00
02 00000003 00000005 fffffffe 09
02 80000000 00000001 7fffffff 02
05 80000000 00000000 80000000 0a
05 00000005 00000000 fffffffb 08
01 80000000 80000000 00000000 07
03 f0f0f0f0 ff00ff00 f000f000 0b
04 0f0f0000 000000ff 0f0f00ff 03
06 a5a5a5a5 a5a5a5a5 00000000 07
07 00000000 00000000 ffffffff 0b
0d 12345678 deadbeef 12345678 03
0e 11111111 87654321 87654321 0b
20 00000000 00000000 00000000 07
21 00000000 7fff0000 7fff0000 03
08 00000002 00000000 00000001 02
09 80000001 00000000 c0000000 0b
0a 40000000 00000000 80000000 0a
0a 80000000 00000000 00000000 07
0b 00000002 00000000 80000001 0a
0b 00000001 00000000 00000000 07
0c 00000000 00000000 00000001 02
0c 80000000 00000000 00000000 07
0c 00000001 00000000 00000003 02
00 ffffffff ffffffff 00000000 02
3f 12345678 00000000 00000000 16
00 00000000 00000000 00000000 16
01 00000001 00000001 00000002 00

//--- project.f
hw/aluPkg.sv
hw/aluDecodedIf.sv
hw/opDecoder.sv
hw/arithUnit.sv
hw/shiftLogicUnit.sv
hw/flagRegister.sv
hw/aluTop.sv
sim/aluTb.sv
